//--- hdl/sd_share_pkg.sv
// shared sd card fabric definitions for client count, idle spi levels and common types
`default_nettype none

package sd_share_pkg;

   //**************************************************************************
   // client numbering
   //**************************************************************************
   localparam int N_SD_CLIENTS = 4;      // rk11, dw, rx01, my in priority order

   // index wide enough to number any client
   typedef logic [$clog2(N_SD_CLIENTS)-1:0] client_idx_t;

   // one bit per client for requests, grants and set strobes
   typedef logic [N_SD_CLIENTS-1:0] client_vec_t;

   //**************************************************************************
   // card line levels with no client attached
   //**************************************************************************
   localparam logic IDLE_CS   = 1'b1;    // card deselected
   localparam logic IDLE_MOSI = 1'b1;    // spi data idles high
   localparam logic IDLE_SCLK = 1'b0;    // clock parked low

   //**************************************************************************
   // activity indication
   //**************************************************************************
   localparam int ACT_HOLD_DEFAULT = 1_000_000;   // ~20 ms at 50 MHz

   // counter wide enough to reach the hold time and stop there
   typedef logic [$clog2(ACT_HOLD_DEFAULT+1)-1:0] act_count_t;

   //**************************************************************************
   // bundled signals
   //**************************************************************************
   // outgoing card lines of one client
   typedef struct packed {
      logic cs;                          // chip select, active low
      logic mosi;                        // data toward the card
      logic sclk;                        // spi clock
   } spi_lines_t;

   // state one client port reports to the picker
   typedef struct packed {
      logic req;                         // filtered request
      logic gnt;                         // card granted to this client
   } port_state_t;

endpackage

`default_nettype wire

//--- hdl/sd_grant_picker.sv
// grant picker choosing which waiting client receives the free sd card
`timescale 1ns/1ps
`default_nettype none

module sd_grant_picker import sd_share_pkg::*; (
   input  port_state_t port_st_i [N_SD_CLIENTS],   // request and grant of each port
   output client_vec_t gnt_set_o                   // one cycle set strobe, at most one hot
);

   logic        any_gnt;     // some client holds the card
   logic        any_req;     // some filtered request is up
   client_idx_t win_idx;     // lowest index asking

   //**************************************************************************
   // priority scan
   //**************************************************************************
   // walk from the top index down so the lowest requester is left in win_idx
   always_comb begin
      any_gnt = 1'b0;
      any_req = 1'b0;
      win_idx = '0;
      for (int i = N_SD_CLIENTS - 1; i >= 0; i--) begin
         if (port_st_i[i].gnt) begin
            any_gnt = 1'b1;
         end
         if (port_st_i[i].req) begin
            any_req = 1'b1;
            win_idx = client_idx_t'(i);
         end
      end
   end

   //**************************************************************************
   // set strobe
   //**************************************************************************
   // only hand out the card when nobody holds it, never pre-empt
   always_comb begin
      gnt_set_o = '0;
      if (!any_gnt && any_req) begin
         gnt_set_o[win_idx] = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hdl/sd_client_port.sv
// client port filtering one sd request and holding that client's grant
`timescale 1ns/1ps
`default_nettype none

module sd_client_port import sd_share_pkg::*; (
   input  logic        clk_sys,
   input  logic        rst_n_i,
   input  logic        req_i,        // raw request level from the controller
   input  logic        gnt_set_i,    // picker says take the card
   output port_state_t port_st_o     // filtered request and grant
);

   logic [1:0] req_ff;   // two stage filter, [1] is the clean copy
   logic       gnt_q;    // card owned

   //**************************************************************************
   // request filter
   //**************************************************************************
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         req_ff <= 2'b00;
      end else begin
         req_ff <= {req_ff[0], req_i};   // shift in raw level
      end
   end

   //**************************************************************************
   // grant register
   //**************************************************************************
   // held until the filtered request drops
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gnt_q <= 1'b0;
      end else if (!req_ff[1]) begin
         gnt_q <= 1'b0;                  // client let go
      end else if (gnt_set_i) begin
         gnt_q <= 1'b1;                  // card handed over
      end
   end

   assign port_st_o.req = req_ff[1];
   assign port_st_o.gnt = gnt_q;

endmodule

`default_nettype wire

//--- hdl/sd_line_switch.sv
// line switch routing the granted client's spi lines to the physical or virtual card
`timescale 1ns/1ps
`default_nettype none

module sd_line_switch import sd_share_pkg::*; (
   input  logic        clk_sys,
   input  logic        rst_n_i,
   input  client_vec_t gnt_i,                       // one hot or zero
   input  spi_lines_t  lines_i [N_SD_CLIENTS],      // lines of every client
   input  logic        img_mounted_i,               // image mount strobe
   input  logic [63:0] img_size_i,                  // size of mounted image
   input  logic        sd_miso_i,                   // physical card data out
   input  logic        vsd_miso_i,                  // virtual card data out
   output logic        sd_cs_o,
   output logic        sd_sck_o,
   output logic        sd_mosi_o,
   output logic        vsd_ss_o,
   output logic        vsd_sck_o,
   output logic        vsd_mosi_o,
   output logic        sd_miso_o,                   // broadcast to all clients
   output logic        vsd_sel_o,                   // virtual card in use
   output logic        card_mosi_o                  // selected mosi before gating
);

   spi_lines_t sel_lines;   // lines of the granted client
   logic       vsd_sel;     // image mounted, use virtual card

   //**************************************************************************
   // client select
   //**************************************************************************
   always_comb begin
      sel_lines.cs   = IDLE_CS;      // nobody granted
      sel_lines.mosi = IDLE_MOSI;
      sel_lines.sclk = IDLE_SCLK;
      for (int i = 0; i < N_SD_CLIENTS; i++) begin
         if (gnt_i[i]) begin
            sel_lines = lines_i[i];
         end
      end
   end

   // a non-empty image switches the fabric to the virtual card
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted_i) begin
         vsd_sel <= |img_size_i;
      end
   end

   //**************************************************************************
   // card gating
   //**************************************************************************
   assign sd_cs_o   = sel_lines.cs | vsd_sel;     // physical card parked deselected
   assign sd_sck_o  = sel_lines.sclk & ~vsd_sel;
   assign sd_mosi_o = sel_lines.mosi & ~vsd_sel;

   assign vsd_ss_o   = sel_lines.cs | ~vsd_sel;   // virtual card only when mounted
   assign vsd_sck_o  = sel_lines.sclk;
   assign vsd_mosi_o = sel_lines.mosi;

   assign sd_miso_o   = vsd_sel ? vsd_miso_i : sd_miso_i;
   assign vsd_sel_o   = vsd_sel;
   assign card_mosi_o = sel_lines.mosi;

endmodule

`default_nettype wire

//--- hdl/sd_activity_led.sv
// activity watcher lighting the user or disk led on sd card data traffic
`timescale 1ns/1ps
`default_nettype none

module sd_activity_led import sd_share_pkg::*; #(
   parameter act_count_t ACT_HOLD = act_count_t'(ACT_HOLD_DEFAULT)   // hold cycles
) (
   input  logic       clk_sys,
   input  logic       rst_n_i,
   input  logic       card_mosi_i,    // mosi of the active card
   input  logic       card_miso_i,    // miso of the active card
   input  logic       vsd_sel_i,      // virtual card in use
   output logic       led_user_o,
   output logic [1:0] led_disk_o
);

   logic       old_mosi;   // lines one cycle back
   logic       old_miso;
   logic       line_chg;   // either data line moved
   act_count_t act_cnt;    // cycles since last change, saturates
   logic       act;

   assign line_chg = (old_mosi ^ card_mosi_i) | (old_miso ^ card_miso_i);

   //**************************************************************************
   // change detect and hold counter
   //**************************************************************************
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         old_mosi <= IDLE_MOSI;
         old_miso <= 1'b1;              // miso is pulled up on the card
         act_cnt  <= ACT_HOLD;          // start dark
      end else begin
         old_mosi <= card_mosi_i;
         old_miso <= card_miso_i;
         if (line_chg) begin
            act_cnt <= '0;              // restart hold
         end else if (act_cnt < ACT_HOLD) begin
            act_cnt <= act_cnt + 1'b1;
         end
      end
   end

   assign act = (act_cnt < ACT_HOLD);

   // user led for the image, disk led for the real card
   assign led_user_o = vsd_sel_i & act;
   assign led_disk_o = {1'b1, ~vsd_sel_i & act};   // upper bit hands led to bit 0

endmodule

`default_nettype wire

//--- hdl/sd_share_top.sv
// shared sd card fabric letting four disk controllers take turns on one card
`timescale 1ns/1ps
`default_nettype none

module sd_share_top import sd_share_pkg::*; #(
   parameter act_count_t ACT_HOLD = act_count_t'(ACT_HOLD_DEFAULT)   // led hold cycles
) (
   input  logic        clk_sys,
   input  logic        rst_n_i,
   input  client_vec_t sd_req_i,                      // request levels
   input  spi_lines_t  client_lines_i [N_SD_CLIENTS], // card lines per client
   input  logic        img_mounted_i,
   input  logic [63:0] img_size_i,
   input  logic        sd_miso_i,
   input  logic        vsd_miso_i,
   output client_vec_t sd_gnt_o,                      // grant levels
   output logic        sd_miso_o,
   output logic        sd_cs_o,
   output logic        sd_sck_o,
   output logic        sd_mosi_o,
   output logic        vsd_ss_o,
   output logic        vsd_sck_o,
   output logic        vsd_mosi_o,
   output logic        led_user_o,
   output logic [1:0]  led_disk_o
);

   port_state_t port_st [N_SD_CLIENTS];   // port to picker
   client_vec_t gnt_set;                  // picker to ports
   logic        vsd_sel;
   logic        card_mosi;

   //**************************************************************************
   // arbitration
   //**************************************************************************
   sd_grant_picker grant_picker (
      .port_st_i (port_st),
      .gnt_set_o (gnt_set)
   );

   for (genvar g = 0; g < N_SD_CLIENTS; g++) begin : g_port
      sd_client_port client_port (
         .clk_sys   (clk_sys),
         .rst_n_i   (rst_n_i),
         .req_i     (sd_req_i[g]),
         .gnt_set_i (gnt_set[g]),
         .port_st_o (port_st[g])
      );
      assign sd_gnt_o[g] = port_st[g].gnt;   // grant straight out
   end

   //**************************************************************************
   // card lines and indication
   //**************************************************************************
   sd_line_switch line_switch (
      .clk_sys       (clk_sys),
      .rst_n_i       (rst_n_i),
      .gnt_i         (sd_gnt_o),
      .lines_i       (client_lines_i),
      .img_mounted_i (img_mounted_i),
      .img_size_i    (img_size_i),
      .sd_miso_i     (sd_miso_i),
      .vsd_miso_i    (vsd_miso_i),
      .sd_cs_o       (sd_cs_o),
      .sd_sck_o      (sd_sck_o),
      .sd_mosi_o     (sd_mosi_o),
      .vsd_ss_o      (vsd_ss_o),
      .vsd_sck_o     (vsd_sck_o),
      .vsd_mosi_o    (vsd_mosi_o),
      .sd_miso_o     (sd_miso_o),
      .vsd_sel_o     (vsd_sel),
      .card_mosi_o   (card_mosi)
   );

   sd_activity_led #(
      .ACT_HOLD (ACT_HOLD)
   ) activity_led (
      .clk_sys     (clk_sys),
      .rst_n_i     (rst_n_i),
      .card_mosi_i (card_mosi),
      .card_miso_i (sd_miso_o),   // miso of whichever card is live
      .vsd_sel_i   (vsd_sel),
      .led_user_o  (led_user_o),
      .led_disk_o  (led_disk_o)
   );

endmodule

`default_nettype wire

//--- sim/sd_share_asserts.sv
// assertion checker for grant exclusivity, grant hand over and physical card parking
`timescale 1ns/1ps
`default_nettype none

module sd_share_asserts import sd_share_pkg::*; (
   input logic        clk_sys,
   input logic        rst_n_i,
   input client_vec_t gnt_i,       // grant levels of the top level
   input logic        sd_cs_i,     // physical chip select
   input logic        vsd_sel_i    // virtual card in use
);

   int fail_cnt = 0;   // failed assertions so far

   gnt_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      $onehot0(gnt_i))
      else begin $error("more than one grant high"); fail_cnt++; end

   // new grant only on a free card
   gnt_free_rise: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      ((gnt_i & ~$past(gnt_i)) != '0) |-> ($past(gnt_i) == '0))
      else begin $error("grant rose while another was held"); fail_cnt++; end

   cs_parked: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      vsd_sel_i |-> sd_cs_i)
      else begin $error("physical chip select low with image mounted"); fail_cnt++; end

endmodule

bind sd_share_top sd_share_asserts share_asserts (
   .clk_sys   (clk_sys),
   .rst_n_i   (rst_n_i),
   .gnt_i     (sd_gnt_o),
   .sd_cs_i   (sd_cs_o),
   .vsd_sel_i (vsd_sel)
);

`default_nettype wire

//--- sim/sd_share_tb.sv
// testbench for the shared sd card fabric, random client lines against a reference pin model
`timescale 1ns/1ps
`default_nettype none

module sd_share_tb import sd_share_pkg::*;;

   localparam int GNT_TIMEOUT = 20;    // grant shows 3 to 4 cycles after a request
   localparam int LED_TIMEOUT = 200;   // well past the 64 cycle hold

   typedef spi_lines_t lines_arr_t [N_SD_CLIENTS];

   // expected card side of the fabric
   typedef struct packed {
      logic cs;
      logic sck;
      logic mosi;
      logic vss;
      logic vsck;
      logic vmosi;
      logic miso;
   } pins_t;

   logic        clk_sys;
   logic        rst_n_i;
   client_vec_t sd_req_i;
   lines_arr_t  client_lines_i;
   logic        img_mounted_i;
   logic [63:0] img_size_i;
   logic        sd_miso_i;
   logic        vsd_miso_i;
   client_vec_t sd_gnt_o;
   logic        sd_miso_o;
   logic        sd_cs_o;
   logic        sd_sck_o;
   logic        sd_mosi_o;
   logic        vsd_ss_o;
   logic        vsd_sck_o;
   logic        vsd_mosi_o;
   logic        led_user_o;
   logic [1:0]  led_disk_o;

   logic        lines_live;           // random lines running
   logic        vsd_model;            // own copy of the virtual select
   logic [31:0] rnd_state = 32'd82;   // xorshift seed

   sd_share_top #(.ACT_HOLD(64)) sd_share_top_i (.*);

   initial begin
      clk_sys = 1'b0;
      forever #5 clk_sys = ~clk_sys;   // 100 MHz
   end

   //**************************************************************************
   // helpers
   //**************************************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // card pins follow the granted client, parked on the physical side when mounted
   function automatic pins_t expect_pins(input client_vec_t gnt, input lines_arr_t lines,
                                         input logic miso_phys, input logic miso_virt,
                                         input logic vsel);
      spi_lines_t sel;
      pins_t      p;
      sel = '{cs: IDLE_CS, mosi: IDLE_MOSI, sclk: IDLE_SCLK};   // no grant
      for (int i = N_SD_CLIENTS - 1; i >= 0; i--) begin
         if (gnt[i]) begin
            sel = lines[i];
         end
      end
      if (vsel) begin
         p = '{cs: 1'b1, sck: 1'b0, mosi: 1'b0, vss: sel.cs, vsck: sel.sclk,
               vmosi: sel.mosi, miso: miso_virt};
      end else begin
         p = '{cs: sel.cs, sck: sel.sclk, mosi: sel.mosi, vss: 1'b1, vsck: sel.sclk,
               vmosi: sel.mosi, miso: miso_phys};
      end
      return p;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         abort_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
      end
   endtask

   task automatic wait_grant(input client_vec_t want, input string what);
      int n;
      n = 0;
      @(negedge clk_sys);
      while (sd_gnt_o !== want) begin
         if (n >= GNT_TIMEOUT) begin
            abort_run($sformatf("timed out waiting for %s", what));
         end else begin
            n++;
            @(negedge clk_sys);
         end
      end
   endtask

   // wait for the user led and the lower disk led bit to reach given levels
   task automatic wait_led(input logic user, input logic disk, input string what);
      int n;
      n = 0;
      @(negedge clk_sys);
      while (led_user_o !== user || led_disk_o[0] !== disk) begin
         if (n >= LED_TIMEOUT) begin
            abort_run($sformatf("timed out waiting for %s", what));
         end else begin
            n++;
            @(negedge clk_sys);
         end
      end
   endtask

   task automatic mount_image(input logic [63:0] size);
      @(posedge clk_sys);
      img_size_i    <= size;
      img_mounted_i <= 1'b1;
      @(posedge clk_sys);
      img_mounted_i <= 1'b0;   // one cycle strobe
   endtask

   //**************************************************************************
   // stimulus, model and checking
   //**************************************************************************
   always @(posedge clk_sys) begin
      if (lines_live) begin
         rnd_state = xorshift32(rnd_state);
         for (int i = 0; i < N_SD_CLIENTS; i++) begin
            client_lines_i[i] <= spi_lines_t'(rnd_state[3*i +: 3]);
         end
         sd_miso_i  <= rnd_state[20];
         vsd_miso_i <= rnd_state[21];
      end
   end

   always @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         vsd_model <= 1'b0;
      end else if (img_mounted_i) begin
         vsd_model <= (img_size_i != 64'd0);   // empty image means real card
      end
   end

   // card side compared with the model mid cycle
   always @(negedge clk_sys) begin
      pins_t want;
      if (rst_n_i) begin
         if (sd_share_top_i.share_asserts.fail_cnt != 0) begin
            abort_run("a bound assertion on the grant or pin rules failed");
         end
         want = expect_pins(sd_gnt_o, client_lines_i, sd_miso_i, vsd_miso_i, vsd_model);
         check_value("sd_cs_o", sd_cs_o, want.cs);
         check_value("sd_sck_o", sd_sck_o, want.sck);
         check_value("sd_mosi_o", sd_mosi_o, want.mosi);
         check_value("vsd_ss_o", vsd_ss_o, want.vss);
         check_value("vsd_sck_o", vsd_sck_o, want.vsck);
         check_value("vsd_mosi_o", vsd_mosi_o, want.vmosi);
         check_value("sd_miso_o", sd_miso_o, want.miso);
      end
   end

   initial begin
      rst_n_i       <= 1'b0;
      sd_req_i      <= '0;
      img_mounted_i <= 1'b0;
      img_size_i    <= '0;
      sd_miso_i     <= 1'b1;
      vsd_miso_i    <= 1'b1;
      lines_live    <= 1'b0;
      for (int i = 0; i < N_SD_CLIENTS; i++) begin
         client_lines_i[i] <= '{cs: IDLE_CS, mosi: IDLE_MOSI, sclk: IDLE_SCLK};
      end
      repeat (8) @(posedge clk_sys);
      rst_n_i <= 1'b1;

      // quiet fabric out of reset
      @(negedge clk_sys);
      check_value("sd_gnt_o", sd_gnt_o, '0);
      check_value("led_user_o", led_user_o, 1'b0);
      check_value("led_disk_o", led_disk_o, 2'b10);

      // single client, then back to idle
      @(posedge clk_sys);
      lines_live <= 1'b1;
      sd_req_i   <= 4'b0100;
      wait_grant(4'b0100, "grant of client 2");
      repeat (20) @(posedge clk_sys);
      sd_req_i <= '0;
      wait_grant(4'b0000, "release of client 2");

      // lowest index wins and keeps the card
      @(posedge clk_sys);
      sd_req_i <= 4'b1010;
      wait_grant(4'b0010, "grant of client 1 over client 3");
      @(posedge clk_sys);
      sd_req_i <= 4'b1011;   // client 0 arrives late
      repeat (12) @(posedge clk_sys);
      @(negedge clk_sys);
      check_value("sd_gnt_o", sd_gnt_o, 4'b0010);
      @(posedge clk_sys);
      sd_req_i <= 4'b1001;
      wait_grant(4'b0001, "grant of waiting client 0");
      @(posedge clk_sys);
      sd_req_i <= 4'b1000;
      wait_grant(4'b1000, "grant of waiting client 3");
      @(posedge clk_sys);
      sd_req_i <= 4'b0100;
      wait_grant(4'b0100, "second grant of client 2");

      // virtual card lights the user led until traffic stops
      mount_image(64'h0000_0000_0040_0000);
      wait_led(1'b1, 1'b0, "user led on the virtual card");
      @(posedge clk_sys);
      lines_live <= 1'b0;
      wait_led(1'b0, 1'b0, "user led going dark");

      // back to the physical card
      @(posedge clk_sys);
      lines_live <= 1'b1;
      mount_image(64'd0);
      wait_led(1'b0, 1'b1, "disk led on the physical card");
      @(posedge clk_sys);
      lines_live <= 1'b0;
      wait_led(1'b0, 1'b0, "disk led going dark");
      @(posedge clk_sys);
      sd_req_i <= '0;
      wait_grant(4'b0000, "final release");

      if (sd_share_top_i.share_asserts.fail_cnt == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         abort_run("a bound assertion on the grant or pin rules failed");
      end
   end

endmodule

`default_nettype wire

//--- flist.f
hdl/sd_share_pkg.sv
hdl/sd_grant_picker.sv
hdl/sd_client_port.sv
hdl/sd_line_switch.sv
hdl/sd_activity_led.sv
hdl/sd_share_top.sv
sim/sd_share_asserts.sv
sim/sd_share_tb.sv

//--- Bender.yml
package:
  name: sd_share

sources:
  - hdl/sd_share_pkg.sv
  - hdl/sd_grant_picker.sv
  - hdl/sd_client_port.sv
  - hdl/sd_line_switch.sv
  - hdl/sd_activity_led.sv
  - hdl/sd_share_top.sv
  - target: test
    files:
      - sim/sd_share_asserts.sv
      - sim/sd_share_tb.sv
